/* flist.f */
design/icache_geom_pkg.sv
design/icache_ctrl_pkg.sv
design/icache_tags.sv
design/icache_data.sv
design/icache_fetch_ctrl.sv
design/icache_top.sv
sim/icache_sva.sv
sim/icache_tb.sv

/* sim/icache_tb.sv */
`timescale 1ns/1ns

module icache_tb;

    localparam int rand_fetches = 40;
    localparam int fetch_count  = rand_fetches + 10;

    logic clk;
    logic rst_n;
    logic fetch_vld;
    icache_geom_pkg::addr_t fetch_pc;
    icache_geom_pkg::slot_mask_t fetch_mask;
    icache_geom_pkg::tag_t fetch_ppn;
    logic flush;
    logic hold;
    logic cacop_vld;
    icache_ctrl_pkg::cacop_t cacop_op;
    icache_geom_pkg::addr_t cacop_addr;
    icache_geom_pkg::slot_mask_t insn_vld;
    icache_geom_pkg::insn_t insn0;
    icache_geom_pkg::insn_t insn1;
    icache_geom_pkg::insn_t insn2;
    icache_geom_pkg::insn_t insn3;
    icache_geom_pkg::addr_t out_pc;
    logic stall;
    logic l2_req;
    icache_geom_pkg::addr_t l2_addr;
    logic l2_ack;
    icache_geom_pkg::line_t l2_data;

    integer seed = 32'h8778;
    int errors;
    int tests;
    int test_err0;
    string cur_test;

    // reference model of valid bits, tags and the shared round-robin pointer
    logic m_valid [icache_geom_pkg::num_sets][icache_geom_pkg::num_ways];
    icache_geom_pkg::tag_t m_tag [icache_geom_pkg::num_sets][icache_geom_pkg::num_ways];
    icache_geom_pkg::way_t m_rr;

    icache_geom_pkg::slot_mask_t last_mask;
    icache_geom_pkg::group_t last_group;

    icache_top dut (.*);

    always #4 clk = ~clk;

    function automatic icache_geom_pkg::insn_t line_word(icache_geom_pkg::addr_t line_addr, int i);
        icache_geom_pkg::insn_t w;
        w = line_addr + 32'(4 * i);
        return (i >= 8) ? ~w : w;   // top half inverted
    endfunction

    function automatic icache_geom_pkg::group_t expected_group(icache_geom_pkg::addr_t line_addr,
                                                               icache_geom_pkg::bank_t bank);
        icache_geom_pkg::group_t g;
        for (int k = 0; k < 4; k++)
            g[k*32 +: 32] = line_word(line_addr, int'(bank) * 4 + k);
        return g;
    endfunction

    function automatic icache_geom_pkg::addr_t random_pc(icache_geom_pkg::set_t s);
        icache_geom_pkg::addr_t pc;
        pc = $random(seed);
        pc[icache_geom_pkg::offset_bits +: icache_geom_pkg::index_bits] = s;
        return pc;
    endfunction

    function automatic logic is_cached(icache_geom_pkg::set_t s, icache_geom_pkg::tag_t t);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < icache_geom_pkg::num_ways; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t)
                hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic record_refill(input icache_geom_pkg::set_t s, input icache_geom_pkg::tag_t t);
        icache_geom_pkg::way_t v;
        logic found;
        found = 1'b0;
        v = m_rr;
        for (int w = icache_geom_pkg::num_ways - 1; w >= 0; w--) begin
            if (!m_valid[s][w]) begin
                v = icache_geom_pkg::way_t'(w);
                found = 1'b1;
            end
        end
        if (!found)
            m_rr = m_rr + 1'b1;   // full set, pointer steps
        m_valid[s][v] = 1'b1;
        m_tag[s][v] = t;
    endtask

    task automatic report_problem(input string what);
        $display("%s: %s", cur_test, what);
        errors++;
    endtask

    task automatic check_group(input icache_geom_pkg::group_t exp, input icache_geom_pkg::group_t act);
        if (exp !== act) begin
            $display("** Error %s: group expected %h, actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_mask(input icache_geom_pkg::slot_mask_t exp,
                              input icache_geom_pkg::slot_mask_t act);
        if (exp !== act) begin
            $display("** Error %s: insn_vld expected %b, actual %b", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input icache_geom_pkg::addr_t exp, input icache_geom_pkg::addr_t act);
        if (exp !== act) begin
            $display("** Error %s: address expected %h, actual %h", cur_test, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err0 = errors;
    endtask

    task automatic close_test();
        tests++;
        if (errors == test_err0)
            $display("%-14s passed", cur_test);
        else
            $display("%-14s failed with %0d errors", cur_test, errors - test_err0);
    endtask

    task automatic fetch_line(input icache_geom_pkg::addr_t pc, input icache_geom_pkg::tag_t ppn);
        icache_geom_pkg::set_t s;
        icache_geom_pkg::addr_t line_addr;
        logic exp_hit;
        s = pc[icache_geom_pkg::offset_bits +: icache_geom_pkg::index_bits];
        line_addr = {ppn, s, {icache_geom_pkg::offset_bits{1'b0}}};
        exp_hit = is_cached(s, ppn);
        last_mask = 4'($random(seed));
        if (last_mask == '0)
            last_mask = 4'hf;
        last_group = expected_group(line_addr, pc[icache_geom_pkg::offset_bits-1 -: 2]);
        @(negedge clk);
        while (stall)
            @(negedge clk);
        fetch_vld = 1'b1;
        fetch_pc = pc;
        fetch_ppn = ppn;   // held until the next fetch
        fetch_mask = last_mask;
        @(posedge clk);
        @(negedge clk);
        fetch_vld = 1'b0;
        if (stall === exp_hit)
            report_problem($sformatf("pc %h expected a %s", pc, exp_hit ? "hit" : "miss"));
        if (!exp_hit) begin
            @(negedge clk);
            if (l2_req !== 1'b1) begin
                report_problem("no L2 request after a miss");
            end else begin
                check_addr(line_addr, l2_addr);
                do @(posedge clk); while (l2_ack !== 1'b1);
            end
            record_refill(s, ppn);
        end
        @(negedge clk);
        check_mask(last_mask, insn_vld);
        check_group(last_group, {insn3, insn2, insn1, insn0});
        check_addr(pc, out_pc);
    endtask

    task automatic flushed_fetch(input icache_geom_pkg::addr_t pc, input icache_geom_pkg::tag_t ppn);
        @(negedge clk);
        fetch_vld = 1'b1;
        fetch_pc = pc;
        fetch_ppn = ppn;
        fetch_mask = 4'hf;
        @(posedge clk);
        @(negedge clk);
        fetch_vld = 1'b0;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check_mask('0, insn_vld);
        @(negedge clk);
        check_mask('0, insn_vld);
    endtask

    // called right after fetch_line, while its outputs are still up
    task automatic hold_outputs();
        hold = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_mask(last_mask, insn_vld);
            check_group(last_group, {insn3, insn2, insn1, insn0});
        end
        hold = 1'b0;
        @(negedge clk);
        check_mask('0, insn_vld);
    endtask

    task automatic cache_op(input icache_ctrl_pkg::cacop_t op, input icache_geom_pkg::addr_t addr);
        icache_geom_pkg::set_t s;
        s = addr[icache_geom_pkg::offset_bits +: icache_geom_pkg::index_bits];
        @(negedge clk);
        cacop_vld = 1'b1;
        cacop_op = op;
        cacop_addr = addr;
        @(negedge clk);
        cacop_vld = 1'b0;
        while (stall)
            @(negedge clk);
        if (op == icache_ctrl_pkg::index_inval) begin
            m_valid[s][addr[1:0]] = 1'b0;
        end else begin
            for (int w = 0; w < icache_geom_pkg::num_ways; w++) begin
                if (m_valid[s][w] && m_tag[s][w] == addr[31 -: icache_geom_pkg::tag_bits])
                    m_valid[s][w] = 1'b0;
            end
        end
    endtask

    // L2 side, acks 1 to 6 cycles after the request
    initial begin
        int delay;
        forever begin
            @(negedge clk);
            l2_ack = 1'b0;
            if (l2_req === 1'b1) begin
                delay = 1 + ($unsigned($random(seed)) % 6);
                repeat (delay - 1)
                    @(negedge clk);
                for (int i = 0; i < 16; i++)
                    l2_data[i*32 +: 32] = line_word(l2_addr, i);
                l2_ack = 1'b1;
            end
        end
    end

    initial begin
        repeat (16 + fetch_count * 20)
            @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        icache_geom_pkg::tag_t ppn_a;
        icache_geom_pkg::tag_t ppn_w;
        icache_geom_pkg::tag_t base;
        icache_geom_pkg::set_t set_a;
        icache_geom_pkg::set_t set_b;
        icache_geom_pkg::way_t w;
        int idx;
        clk = 1'b0;
        rst_n = 1'b0;
        fetch_vld = 1'b0;
        fetch_pc = '0;
        fetch_mask = '0;
        fetch_ppn = '0;
        flush = 1'b0;
        hold = 1'b0;
        cacop_vld = 1'b0;
        cacop_op = icache_ctrl_pkg::index_inval;
        cacop_addr = '0;
        l2_ack = 1'b0;
        l2_data = '0;
        errors = 0;
        tests = 0;
        m_rr = '0;
        for (int s = 0; s < icache_geom_pkg::num_sets; s++) begin
            for (int k = 0; k < icache_geom_pkg::num_ways; k++)
                m_valid[s][k] = 1'b0;
        end
        repeat (16)
            @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        set_a = 6'h03;
        set_b = 6'h15;
        ppn_a = icache_geom_pkg::tag_t'($random(seed));
        base = icache_geom_pkg::tag_t'($random(seed));

        start_test("cold_miss");
        fetch_line(random_pc(set_a), ppn_a);
        close_test();

        start_test("refetch_hit");
        fetch_line(random_pc(set_a), ppn_a);
        close_test();

        start_test("victim_choice");   // five lines competing for four ways
        repeat (rand_fetches) begin
            idx = $unsigned($random(seed)) % 5;
            fetch_line(random_pc(set_b), base + icache_geom_pkg::tag_t'(idx));
        end
        close_test();

        start_test("index_inval");
        w = icache_geom_pkg::way_t'($random(seed));
        ppn_w = m_tag[set_b][w];
        cache_op(icache_ctrl_pkg::index_inval,
                 {icache_geom_pkg::tag_t'($random(seed)), set_b, 4'b0000, w});
        fetch_line(random_pc(set_b), ppn_w);
        close_test();

        start_test("hit_inval");
        cache_op(icache_ctrl_pkg::hit_inval, {ppn_a, set_a, 6'b0});
        fetch_line(random_pc(set_a), ppn_a);
        cache_op(icache_ctrl_pkg::hit_inval, {base + 20'd7, set_b, 6'b0});   // not cached
        for (int k = 0; k < icache_geom_pkg::num_ways; k++)
            fetch_line(random_pc(set_b), m_tag[set_b][k]);
        close_test();

        start_test("flush_hold");
        flushed_fetch(random_pc(set_a), ppn_a);
        fetch_line(random_pc(set_a), ppn_a);
        hold_outputs();
        close_test();

        if (dut.u_sva.fail_count != 0)
            report_problem("concurrent assertions failed during the run");
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* sim/icache_sva.sv */
`timescale 1ns/1ns

module icache_sva (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  stall,
    input logic                                  l2_req,
    input logic                                  l2_ack,
    input icache_geom_pkg::addr_t                l2_addr,
    input logic [icache_geom_pkg::num_ways-1:0]  way_hit
);

    int fail_count = 0;   // assertion failures so far

    req_stalls: assert property (@(posedge clk) disable iff (!rst_n) l2_req |-> stall)
        else begin
            $error("l2_req raised while stall is low");
            fail_count++;
        end

    // address must not move until the line comes back
    addr_steady: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req && !l2_ack |=> $stable(l2_addr))
        else begin
            $error("l2_addr changed during an open L2 request");
            fail_count++;
        end

    single_hit: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(way_hit))
        else begin
            $error("more than one way hit in the same lookup");
            fail_count++;
        end

endmodule

bind icache_top icache_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .stall   (stall),
    .l2_req  (l2_req),
    .l2_ack  (l2_ack),
    .l2_addr (l2_addr),
    .way_hit (way_hit)
);

/* design/icache_top.sv */
`timescale 1ns/1ns

module icache_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         fetch_vld,
    input  icache_geom_pkg::addr_t       fetch_pc,
    input  icache_geom_pkg::slot_mask_t  fetch_mask,
    input  icache_geom_pkg::tag_t        fetch_ppn,
    input  logic                         flush,
    input  logic                         hold,
    input  logic                         cacop_vld,
    input  icache_ctrl_pkg::cacop_t      cacop_op,
    input  icache_geom_pkg::addr_t       cacop_addr,
    output icache_geom_pkg::slot_mask_t  insn_vld,
    output icache_geom_pkg::insn_t       insn0,
    output icache_geom_pkg::insn_t       insn1,
    output icache_geom_pkg::insn_t       insn2,
    output icache_geom_pkg::insn_t       insn3,
    output icache_geom_pkg::addr_t       out_pc,
    output logic                         stall,
    output logic                         l2_req,
    output icache_geom_pkg::addr_t       l2_addr,
    input  logic                         l2_ack,
    input  icache_geom_pkg::line_t       l2_data
);

    logic lookup_en;
    icache_geom_pkg::set_t lookup_set;
    icache_geom_pkg::set_t rd_set;
    icache_geom_pkg::bank_t rd_bank;
    logic refill_wr;
    logic probe;
    logic [icache_geom_pkg::num_ways-1:0] way_hit;
    logic any_hit;
    icache_geom_pkg::way_t victim_way;
    icache_geom_pkg::group_t [icache_geom_pkg::num_ways-1:0] way_group;

    icache_tags u_tags (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_en  (lookup_en),
        .lookup_set (lookup_set),
        .ppn        (fetch_ppn),
        .refill_wr  (refill_wr),
        .refill_set (rd_set),      // refill always targets the stage-1 set
        .cacop_vld  (cacop_vld),
        .cacop_op   (cacop_op),
        .cacop_addr (cacop_addr),
        .probe      (probe),
        .way_hit    (way_hit),
        .any_hit    (any_hit),
        .victim_way (victim_way)
    );

    icache_data u_data (
        .clk        (clk),
        .refill_wr  (refill_wr),
        .refill_set (rd_set),
        .victim_way (victim_way),
        .l2_data    (l2_data),
        .rd_set     (rd_set),
        .rd_bank    (rd_bank),
        .way_group  (way_group)
    );

    icache_fetch_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_vld  (fetch_vld),
        .fetch_pc   (fetch_pc),
        .fetch_mask (fetch_mask),
        .fetch_ppn  (fetch_ppn),
        .flush      (flush),
        .hold       (hold),
        .cacop_vld  (cacop_vld),
        .cacop_op   (cacop_op),
        .way_hit    (way_hit),
        .any_hit    (any_hit),
        .way_group  (way_group),
        .l2_ack     (l2_ack),
        .l2_data    (l2_data),
        .lookup_en  (lookup_en),
        .lookup_set (lookup_set),
        .rd_set     (rd_set),
        .rd_bank    (rd_bank),
        .refill_wr  (refill_wr),
        .probe      (probe),
        .stall      (stall),
        .l2_req     (l2_req),
        .l2_addr    (l2_addr),
        .insn_vld   (insn_vld),
        .insn0      (insn0),
        .insn1      (insn1),
        .insn2      (insn2),
        .insn3      (insn3),
        .out_pc     (out_pc)
    );

endmodule

/* design/icache_fetch_ctrl.sv */
`timescale 1ns/1ns

module icache_fetch_ctrl (
    input  logic                                                     clk,
    input  logic                                                     rst_n,
    input  logic                                                     fetch_vld,
    input  icache_geom_pkg::addr_t                                   fetch_pc,
    input  icache_geom_pkg::slot_mask_t                              fetch_mask,
    input  icache_geom_pkg::tag_t                                    fetch_ppn,
    input  logic                                                     flush,
    input  logic                                                     hold,
    input  logic                                                     cacop_vld,
    input  icache_ctrl_pkg::cacop_t                                  cacop_op,
    input  logic [icache_geom_pkg::num_ways-1:0]                     way_hit,
    input  logic                                                     any_hit,
    input  icache_geom_pkg::group_t [icache_geom_pkg::num_ways-1:0]  way_group,
    input  logic                                                     l2_ack,
    input  icache_geom_pkg::line_t                                   l2_data,
    output logic                                                     lookup_en,
    output icache_geom_pkg::set_t                                    lookup_set,
    output icache_geom_pkg::set_t                                    rd_set,
    output icache_geom_pkg::bank_t                                   rd_bank,
    output logic                                                     refill_wr,
    output logic                                                     probe,
    output logic                                                     stall,
    output logic                                                     l2_req,
    output icache_geom_pkg::addr_t                                   l2_addr,
    output icache_geom_pkg::slot_mask_t                              insn_vld,
    output icache_geom_pkg::insn_t                                   insn0,
    output icache_geom_pkg::insn_t                                   insn1,
    output icache_geom_pkg::insn_t                                   insn2,
    output icache_geom_pkg::insn_t                                   insn3,
    output icache_geom_pkg::addr_t                                   out_pc
);

    icache_ctrl_pkg::ctrl_state_t state_q;
    icache_ctrl_pkg::ctrl_state_t state_d;

    icache_geom_pkg::addr_t s1_pc;
    icache_geom_pkg::slot_mask_t s1_mask;
    logic s1_vld;

    logic hit;
    logic miss;
    logic hit_inval_req;
    logic start_refill;
    logic out_load;
    icache_geom_pkg::group_t hit_group;
    icache_geom_pkg::group_t out_group;

    assign hit  = s1_vld && any_hit;
    assign miss = s1_vld && !any_hit;
    assign hit_inval_req = cacop_vld && (cacop_op == icache_ctrl_pkg::hit_inval);

    assign stall = (state_q != icache_ctrl_pkg::lookup) || miss || hit_inval_req;
    assign lookup_en  = fetch_vld && !stall && !hold && !flush;
    assign lookup_set = fetch_pc[icache_geom_pkg::offset_bits +: icache_geom_pkg::index_bits];

    assign rd_set  = s1_pc[icache_geom_pkg::offset_bits +: icache_geom_pkg::index_bits];
    assign rd_bank = s1_pc[icache_geom_pkg::offset_bits-1 -: $bits(icache_geom_pkg::bank_t)];

    assign refill_wr = (state_q == icache_ctrl_pkg::refill) && l2_ack;
    assign probe     = (state_q == icache_ctrl_pkg::probe);
    assign l2_req    = (state_q == icache_ctrl_pkg::refill);
    assign start_refill = (state_q == icache_ctrl_pkg::lookup) && miss && !flush && !hold;

    always_comb begin
        case (state_q)
            icache_ctrl_pkg::lookup: begin
                if (start_refill)
                    state_d = icache_ctrl_pkg::refill;
                else if (hit_inval_req)
                    state_d = icache_ctrl_pkg::probe;
                else
                    state_d = icache_ctrl_pkg::lookup;
            end
            icache_ctrl_pkg::refill:
                state_d = l2_ack ? icache_ctrl_pkg::lookup : icache_ctrl_pkg::refill;
            default:
                state_d = icache_ctrl_pkg::lookup;   // probe lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= icache_ctrl_pkg::lookup;
        else
            state_q <= state_d;
    end

    // stage 1 stays put while a miss waits for its line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s1_vld <= 1'b0;
        else if (flush)
            s1_vld <= 1'b0;
        else if (refill_wr && !hold)
            s1_vld <= 1'b0;
        else if (!hold && !miss)
            s1_vld <= lookup_en;
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            s1_pc   <= fetch_pc;
            s1_mask <= fetch_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (start_refill)
            l2_addr <= {fetch_ppn, rd_set, {icache_geom_pkg::offset_bits{1'b0}}};
    end

    always_comb begin
        hit_group = '0;
        for (int w = 0; w < icache_geom_pkg::num_ways; w++) begin
            if (way_hit[w])
                hit_group = hit_group | way_group[w];   // one-hot or-mux
        end
    end

    assign out_group = refill_wr ?
        l2_data[rd_bank*$bits(icache_geom_pkg::group_t) +: $bits(icache_geom_pkg::group_t)] :
        hit_group;
    assign out_load = !flush && !hold && (hit || (refill_wr && s1_vld));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            insn_vld <= '0;
        else if (flush)
            insn_vld <= '0;
        else if (!hold)
            insn_vld <= out_load ? s1_mask : '0;
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            {insn3, insn2, insn1, insn0} <= out_group;
            out_pc <= s1_pc;
        end
    end

endmodule

/* design/icache_data.sv */
`timescale 1ns/1ns

module icache_data (
    input  logic                                                     clk,
    input  logic                                                     refill_wr,
    input  icache_geom_pkg::set_t                                    refill_set,
    input  icache_geom_pkg::way_t                                    victim_way,
    input  icache_geom_pkg::line_t                                   l2_data,
    input  icache_geom_pkg::set_t                                    rd_set,
    input  icache_geom_pkg::bank_t                                   rd_bank,
    output icache_geom_pkg::group_t [icache_geom_pkg::num_ways-1:0]  way_group
);

    // one storage block per way, each split into four 128-bit banks
    for (genvar w = 0; w < icache_geom_pkg::num_ways; w++) begin : g_way
        icache_geom_pkg::group_t bank_q [2**$bits(icache_geom_pkg::bank_t)]
                                        [icache_geom_pkg::num_sets];
        logic way_wr;

        assign way_wr = refill_wr && (victim_way == icache_geom_pkg::way_t'(w));

        always_ff @(posedge clk) begin
            if (way_wr) begin
                for (int b = 0; b < 2**$bits(icache_geom_pkg::bank_t); b++) begin
                    bank_q[b][refill_set] <=
                        l2_data[b*$bits(icache_geom_pkg::group_t) +:
                                $bits(icache_geom_pkg::group_t)];
                end
            end
        end

        assign way_group[w] = bank_q[rd_bank][rd_set];   // async read
    end

endmodule

/* design/icache_tags.sv */
`timescale 1ns/1ns

module icache_tags (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  lookup_en,
    input  icache_geom_pkg::set_t                 lookup_set,
    input  icache_geom_pkg::tag_t                 ppn,
    input  logic                                  refill_wr,
    input  icache_geom_pkg::set_t                 refill_set,
    input  logic                                  cacop_vld,
    input  icache_ctrl_pkg::cacop_t               cacop_op,
    input  icache_geom_pkg::addr_t                cacop_addr,
    input  logic                                  probe,
    output logic [icache_geom_pkg::num_ways-1:0]  way_hit,
    output logic                                  any_hit,
    output icache_geom_pkg::way_t                 victim_way
);

    logic [icache_geom_pkg::num_ways-1:0] valid_q [icache_geom_pkg::num_sets];
    icache_geom_pkg::tag_t tag_q [icache_geom_pkg::num_ways][icache_geom_pkg::num_sets];

    logic [icache_geom_pkg::num_ways-1:0] s1_valid;
    icache_geom_pkg::tag_t s1_tag [icache_geom_pkg::num_ways];

    logic [icache_geom_pkg::num_ways-1:0] pr_valid;
    icache_geom_pkg::tag_t pr_tag [icache_geom_pkg::num_ways];
    icache_geom_pkg::set_t pr_set;
    icache_geom_pkg::tag_t pr_ppn;
    logic [icache_geom_pkg::num_ways-1:0] pr_hit;

    icache_geom_pkg::way_t rr_ptr;
    logic [icache_geom_pkg::num_ways-1:0] refill_valid;
    logic set_full;

    icache_geom_pkg::set_t cacop_set;
    icache_geom_pkg::tag_t cacop_tag;
    icache_geom_pkg::way_t cacop_way;
    logic index_inval_en;
    logic hit_inval_en;

    assign cacop_set = cacop_addr[icache_geom_pkg::offset_bits +: icache_geom_pkg::index_bits];
    assign cacop_tag = cacop_addr[$bits(icache_geom_pkg::addr_t)-1 -: icache_geom_pkg::tag_bits];
    assign cacop_way = cacop_addr[1:0];   // way select for index_inval
    assign index_inval_en = cacop_vld && (cacop_op == icache_ctrl_pkg::index_inval);
    assign hit_inval_en   = cacop_vld && (cacop_op == icache_ctrl_pkg::hit_inval);

    always_comb begin
        for (int w = 0; w < icache_geom_pkg::num_ways; w++) begin
            way_hit[w] = s1_valid[w] && (s1_tag[w] == ppn);
            pr_hit[w]  = pr_valid[w] && (pr_tag[w] == pr_ppn);
        end
    end

    assign any_hit = |way_hit;

    // lowest invalid way, round-robin once the set is full
    always_comb begin
        refill_valid = valid_q[refill_set];
        set_full     = &refill_valid;
        victim_way   = rr_ptr;
        if (!set_full) begin
            for (int w = icache_geom_pkg::num_ways - 1; w >= 0; w--) begin
                if (!refill_valid[w])
                    victim_way = icache_geom_pkg::way_t'(w);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rr_ptr <= '0;
        else if (refill_wr && set_full)
            rr_ptr <= rr_ptr + 1'b1;   // only moves on a refill
    end

    // stage-1 copy of the looked-up set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s1_valid <= '0;
        else if (lookup_en)
            s1_valid <= valid_q[lookup_set];
        else if (refill_wr)
            s1_valid[victim_way] <= 1'b1;   // keep stage 1 coherent with the new line
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            for (int w = 0; w < icache_geom_pkg::num_ways; w++)
                s1_tag[w] <= tag_q[w][lookup_set];
        end else if (refill_wr) begin
            s1_tag[victim_way] <= ppn;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pr_valid <= '0;
        else if (hit_inval_en)
            pr_valid <= valid_q[cacop_set];
    end

    always_ff @(posedge clk) begin
        if (hit_inval_en) begin
            pr_set <= cacop_set;
            pr_ppn <= cacop_tag;
            for (int w = 0; w < icache_geom_pkg::num_ways; w++)
                pr_tag[w] <= tag_q[w][cacop_set];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < icache_geom_pkg::num_sets; s++)
                valid_q[s] <= '0;
        end else begin
            if (index_inval_en)
                valid_q[cacop_set][cacop_way] <= 1'b0;
            if (probe) begin
                for (int w = 0; w < icache_geom_pkg::num_ways; w++) begin
                    if (pr_hit[w])
                        valid_q[pr_set][w] <= 1'b0;
                end
            end
            if (refill_wr)
                valid_q[refill_set][victim_way] <= 1'b1;   // refill wins
        end
    end

    always_ff @(posedge clk) begin
        if (refill_wr)
            tag_q[victim_way][refill_set] <= ppn;
    end

endmodule

/* design/icache_ctrl_pkg.sv */
package icache_ctrl_pkg;

    // fetch controller states
    typedef enum logic [1:0] {
        lookup = 2'd0,
        refill = 2'd1,   // waiting on L2 line
        probe  = 2'd2    // hit-invalidate compare cycle
    } ctrl_state_t;

    // cache maintenance operations
    typedef enum logic {
        index_inval = 1'b0,
        hit_inval   = 1'b1
    } cacop_t;

endpackage

/* design/icache_geom_pkg.sv */
package icache_geom_pkg;

    localparam int num_ways    = 4;
    localparam int num_sets    = 64;
    localparam int offset_bits = 6;    // 64-byte line
    localparam int index_bits  = 6;
    localparam int tag_bits    = 20;   // physical page number
    localparam int slots       = 4;    // instructions per fetch group

    typedef logic [31:0] addr_t;

    typedef logic [tag_bits-1:0] tag_t;

    typedef logic [index_bits-1:0] set_t;

    typedef logic [$clog2(num_ways)-1:0] way_t;

    typedef logic [1:0] bank_t;        // 16-byte bank within a line

    typedef logic [31:0] insn_t;

    typedef logic [slots*32-1:0] group_t;

    typedef logic [4*slots*32-1:0] line_t;

    typedef logic [slots-1:0] slot_mask_t;

endpackage
